// File: Makefile
# Verilator build and regression run for the compute unit

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := compute_unit_tb
FILELIST := sim.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: include/dsp_defs.svh
// word width, register count, register index width and compare history depth macros
`ifndef DSP_DEFS_SVH
`define DSP_DEFS_SVH

// ********************
// datapath sizing
// ********************

`define DSP_DATA_WIDTH 16 // one fixed-point word

`define DSP_REG_COUNT  16 // data registers r0..r15
`define DSP_REG_IDX_W  4  // log2 of the register count

// ********************
// status unit
// ********************

`define DSP_CACC_DEPTH 8  // compare accumulator, last eight compares

`endif

// File: sim.f
+incdir+include
source/dsp_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/alu.sv
source/alu_status.sv
source/compute_unit.sv
verification/compute_unit_assertions.sv
verification/compute_unit_tb.sv

// File: source/alu.sv
// sixteen-bit ALU with operand latches, operation mux, ripple-carry adder, flags, saturation
`timescale 1ns/1ps
`include "dsp_defs.svh"

module alu
(
	input  logic           clk,
	input  logic           reset,
	input  dsp_pkg::data_t xb_dtx,
	input  dsp_pkg::data_t xb_dty,
	input  logic           ps_alu_en,
	input  logic           ps_alu_log,
	input  logic           ps_alu_sat,
	input  logic           ps_alu_ci,    // AC from the previous instruction
	input  logic [1:0]     ps_alu_hc,
	input  logic [2:0]     ps_alu_sc,
	output dsp_pkg::data_t alu_xb_dt,
	output logic           alu_ps_az,
	output logic           alu_ps_an,
	output logic           alu_ps_ac,
	output logic           alu_ps_av,
	output logic           alu_ps_compd
);

	localparam int W = `DSP_DATA_WIDTH;

	dsp_pkg::data_t x, y;           // latched operands
	logic           alu_en;         // execute cycle marker
	logic           alu_log, alu_sat;
	logic [1:0]     alu_hc;
	logic [2:0]     alu_sc;

	dsp_pkg::data_t add_a, add_b, sum;
	logic           add_ci;
	logic [W:0]     carry;          // carry[i] into bit i
	logic           ovf;            // signed overflow of the adder
	logic           lt;             // x < y signed, from x - y
	logic           is_cmp, no_flags;
	dsp_pkg::data_t raw;            // result before saturation

	// ********************
	// latches
	// ********************

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			alu_en  <= 1'b0;
			alu_log <= 1'b0;
			alu_hc  <= 2'b00;
			alu_sc  <= 3'b000;
			alu_sat <= 1'b0;
		end
		else
		begin
			alu_en <= ps_alu_en;
			if (ps_alu_en)
			begin
				alu_log <= ps_alu_log;
				alu_hc  <= ps_alu_hc;
				alu_sc  <= ps_alu_sc;
				alu_sat <= ps_alu_sat; // held until the next issue
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (ps_alu_en)
			x <= xb_dtx;
		if (ps_alu_en && !ps_alu_hc[1])
			y <= xb_dty; // unary classes keep the old y
	end

	// ********************
	// adder operands
	// ********************

	always_comb
	begin
		add_a  = x;
		add_b  = '0;
		add_ci = 1'b0;
		if (!alu_log)
		begin
			case (alu_hc)
				2'b00:
				begin
					add_b  = y ^ {W{alu_sc[0]}}; // invert y for subtract and compare
					add_ci = alu_sc[1] ? ps_alu_ci : alu_sc[0]; // ci, or ci-1 with ~y
				end
				2'b01:
				begin
					add_b  = ~y; // x - y picks min/max
					add_ci = 1'b1;
				end
				2'b10:
				begin
					add_a  = x ^ {W{alu_sc[0]}}; // -x = ~x + 1, else pass
					add_ci = alu_sc[0];
				end
				default:
				begin
					add_a  = x ^ {W{x[W-1]}}; // abs, negate only when x < 0
					add_ci = x[W-1];
				end
			endcase
		end
	end

	// ripple-carry chain
	always_comb
	begin
		carry[0] = add_ci;
		for (int i = 0; i < W; i++)
		begin
			sum[i]     = add_a[i] ^ add_b[i] ^ carry[i];
			carry[i+1] = (add_a[i] & add_b[i]) | (add_a[i] & carry[i]) | (add_b[i] & carry[i]);
		end
	end

	assign ovf      = carry[W] ^ carry[W-1];
	assign lt       = sum[W-1] ^ ovf;
	assign is_cmp   = !alu_log && (alu_hc == 2'b00) && (alu_sc == 3'b101);
	assign no_flags = alu_log | is_cmp | (alu_hc == 2'b01); // logical, compare, min, max

	// ********************
	// operation mux
	// ********************

	always_comb
	begin
		if (alu_log)
		begin
			case (alu_hc)
				2'b00:
				begin
					case (alu_sc[1:0])
						2'b00:   raw = x & y;
						2'b01:   raw = x | y;
						2'b10:   raw = x ^ y;
						default: raw = '0; // unused code
					endcase
				end
				2'b10:   raw = {{(W-1){1'b0}}, (alu_sc[0] ? |x : &x)};
				2'b11:   raw = ~x;
				default: raw = '0;
			endcase
		end
		else
		begin
			case (alu_hc)
				2'b00:
				begin
					if (is_cmp)
						raw = lt ? '1 : ((sum == '0) ? '0 : dsp_pkg::data_t'(1)); // ffff / 0 / 1
					else
						raw = sum;
				end
				2'b01:   raw = alu_sc[1] ? (lt ? y : x) : (lt ? x : y); // max : min
				default: raw = sum; // negate, pass, abs
			endcase
		end
	end

	// flags, AV taken before the clamp
	assign alu_ps_ac = carry[W] & ~no_flags;
	assign alu_ps_av = ovf & ~no_flags;

	// sign of the wrapped sum tells the overflow direction
	assign alu_xb_dt = (alu_sat && alu_ps_av) ?
		(sum[W-1] ? {1'b0, {(W-1){1'b1}}} : {1'b1, {(W-1){1'b0}}}) : raw;

	assign alu_ps_az    = (alu_xb_dt == '0);
	assign alu_ps_an    = alu_xb_dt[W-1];
	assign alu_ps_compd = alu_en & is_cmp;

endmodule

// File: source/alu_status.sv
// arithmetic flag register, sticky overflow bit and compare accumulator
`timescale 1ns/1ps
`include "dsp_defs.svh"

module alu_status
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       exec_valid,   // ALU execute cycle
	input  logic                       az,
	input  logic                       an,
	input  logic                       ac,
	input  logic                       av,
	input  logic                       compd,        // execute cycle holds a compare
	input  logic                       sticky_clear,
	output logic                       flag_az,
	output logic                       flag_an,
	output logic                       flag_ac,      // also the ALU carry input
	output logic                       flag_av,
	output logic                       sticky_ov,
	output logic [`DSP_CACC_DEPTH-1:0] cacc
);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			flag_az   <= 1'b0;
			flag_an   <= 1'b0;
			flag_ac   <= 1'b0;
			flag_av   <= 1'b0;
			sticky_ov <= 1'b0;
			cacc      <= '0;
		end
		else
		begin
			if (exec_valid)
			begin
				flag_az <= az;
				flag_an <= an;
				flag_ac <= ac;
				flag_av <= av;
			end
			// clear first, a new overflow on the same edge sets it again
			sticky_ov <= (sticky_ov & ~sticky_clear) | (exec_valid & av);
			if (exec_valid && compd)
				cacc <= {cacc[`DSP_CACC_DEPTH-2:0], an}; // newest "x < y" in bit 0
		end
	end

endmodule

// File: source/compute_unit.sv
// compute unit top level with decoder, register file, ALU and status unit
`timescale 1ns/1ps
`include "dsp_defs.svh"

module compute_unit
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       instr_valid,
	input  dsp_pkg::instr_t            instr,
	input  logic                       load_en,
	input  dsp_pkg::reg_idx_t          load_addr,
	input  dsp_pkg::data_t             load_data,
	input  logic                       sticky_clear,
	output dsp_pkg::data_t             result,
	output logic                       result_valid,
	output logic                       flag_az,
	output logic                       flag_an,
	output logic                       flag_ac,
	output logic                       flag_av,
	output logic                       sticky_ov,
	output logic [`DSP_CACC_DEPTH-1:0] cacc
);

	dsp_pkg::reg_idx_t rd_x_addr, rd_y_addr, wb_addr;
	dsp_pkg::data_t    xb_dtx, xb_dty, alu_xb_dt;
	logic              ps_alu_en, ps_alu_log, ps_alu_sat, wb_en;
	logic [1:0]        ps_alu_hc;
	logic [2:0]        ps_alu_sc;
	logic              alu_ps_az, alu_ps_an, alu_ps_ac, alu_ps_av, alu_ps_compd;

	instr_decode u_decode (.clk, .reset, .instr_valid, .instr, .rd_x_addr, .rd_y_addr,
		.ps_alu_en, .ps_alu_log, .ps_alu_sat, .ps_alu_hc, .ps_alu_sc, .wb_en, .wb_addr);

	reg_file u_regs (.clk, .reset, .rd_x_addr, .rd_y_addr, .xb_dtx, .xb_dty, .wb_en,
		.wb_addr, .wb_data(alu_xb_dt), .load_en, .load_addr, .load_data);

	// carry in is the registered AC
	alu u_alu (.clk, .reset, .xb_dtx, .xb_dty, .ps_alu_en, .ps_alu_log, .ps_alu_sat,
		.ps_alu_ci(flag_ac), .ps_alu_hc, .ps_alu_sc, .alu_xb_dt, .alu_ps_az, .alu_ps_an,
		.alu_ps_ac, .alu_ps_av, .alu_ps_compd);

	alu_status u_status (.clk, .reset, .exec_valid(wb_en), .az(alu_ps_az), .an(alu_ps_an),
		.ac(alu_ps_ac), .av(alu_ps_av), .compd(alu_ps_compd), .sticky_clear, .flag_az,
		.flag_an, .flag_ac, .flag_av, .sticky_ov, .cacc);

	assign result       = alu_xb_dt; // valid in the execute cycle only
	assign result_valid = wb_en;

endmodule

// File: source/dsp_pkg.sv
// data word type, register index type and instruction word struct
`include "dsp_defs.svh"

package dsp_pkg;

	// one data word on the X, Y and result buses
	typedef logic [`DSP_DATA_WIDTH-1:0] data_t;

	// register file index
	typedef logic [`DSP_REG_IDX_W-1:0] reg_idx_t;

	// ********************
	// instruction word
	// ********************
	// 19 bits, msb first
	// sat, log, hc, sc select the operation
	// rn is written back, rx and ry are read

	typedef struct packed {
		logic       sat; // saturate on overflow
		logic       log; // logical group when set
		logic [1:0] hc;  // operation class
		logic [2:0] sc;  // sub-code within class
		reg_idx_t   rn;  // destination
		reg_idx_t   rx;  // x source
		reg_idx_t   ry;  // y source
	} instr_t;

endpackage

// File: source/instr_decode.sv
// instruction decoder with ALU control fan-out and write-back index pipeline
`timescale 1ns/1ps

module instr_decode
(
	input  logic              clk,
	input  logic              reset,
	input  logic              instr_valid, // one strobe per instruction
	input  dsp_pkg::instr_t   instr,
	output dsp_pkg::reg_idx_t rd_x_addr,
	output dsp_pkg::reg_idx_t rd_y_addr,
	output logic              ps_alu_en,
	output logic              ps_alu_log,
	output logic              ps_alu_sat,
	output logic [1:0]        ps_alu_hc,
	output logic [2:0]        ps_alu_sc,
	output logic              wb_en,
	output dsp_pkg::reg_idx_t wb_addr
);

	// issue stage, straight from the instruction word
	assign rd_x_addr  = instr.rx; // register file reads same cycle
	assign rd_y_addr  = instr.ry;
	assign ps_alu_en  = instr_valid; // ALU latches on this
	assign ps_alu_log = instr.log;
	assign ps_alu_sat = instr.sat;
	assign ps_alu_hc  = instr.hc;
	assign ps_alu_sc  = instr.sc;

	// write-back stage, lines up with the ALU execute cycle
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			wb_en <= 1'b0;
		else
			wb_en <= instr_valid; // next issue may overlap this one
	end

	always_ff @(posedge clk)
	begin
		wb_addr <= instr.rn; // only looked at while wb_en
	end

endmodule

// File: source/reg_file.sv
// data register file with two asynchronous read ports, write-back bypass and load port
`timescale 1ns/1ps
`include "dsp_defs.svh"

module reg_file
(
	input  logic              clk,
	input  logic              reset,
	input  dsp_pkg::reg_idx_t rd_x_addr,
	input  dsp_pkg::reg_idx_t rd_y_addr,
	output dsp_pkg::data_t    xb_dtx,
	output dsp_pkg::data_t    xb_dty,
	input  logic              wb_en,
	input  dsp_pkg::reg_idx_t wb_addr,
	input  dsp_pkg::data_t    wb_data,
	input  logic              load_en,   // never together with wb_en
	input  dsp_pkg::reg_idx_t load_addr,
	input  dsp_pkg::data_t    load_data
);

	dsp_pkg::data_t regs [`DSP_REG_COUNT]; // r0..r15

	// ********************
	// write side
	// ********************

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < `DSP_REG_COUNT; i++)
				regs[i] <= '0; // all registers read zero after reset
		end
		else if (wb_en)
			regs[wb_addr] <= wb_data; // ALU result
		else if (load_en)
			regs[load_addr] <= load_data; // external preload
	end

	// ********************
	// read side
	// ********************
	// the result still in flight is forwarded
	// so a dependent instruction issued back-to-back sees it

	assign xb_dtx = (wb_en && (rd_x_addr == wb_addr)) ? wb_data : regs[rd_x_addr];
	assign xb_dty = (wb_en && (rd_y_addr == wb_addr)) ? wb_data : regs[rd_y_addr];

endmodule

// File: verification/compute_unit_assertions.sv
// bound checks on load and write-back overlap, result timing and flags after reset
`timescale 1ns/1ps

module compute_unit_assertions
(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic load_en,
	input logic result_valid, // same as the write-back enable
	input logic flag_az,
	input logic flag_an,
	input logic flag_ac,
	input logic flag_av
);

	int fail_count = 0; // assertion failures so far

	// load port shares the register write path with write-back
	load_vs_writeback: assert property (@(posedge clk) disable iff (!reset)
		!(load_en && result_valid))
		else
		begin
			$error("load_en high in a write-back cycle");
			fail_count++;
		end

	// one cycle from issue to result
	result_timing: assert property (@(posedge clk) disable iff (!reset)
		result_valid == $past(instr_valid))
		else
		begin
			$error("result_valid does not follow instr_valid by one cycle");
			fail_count++;
		end

	flags_after_reset: assert property (@(posedge clk)
		$rose(reset) |-> !(flag_az || flag_an || flag_ac || flag_av))
		else
		begin
			$error("flags not clear after reset release");
			fail_count++;
		end

endmodule

bind compute_unit compute_unit_assertions u_checks (.clk(clk), .reset(reset),
	.instr_valid(instr_valid), .load_en(load_en), .result_valid(result_valid),
	.flag_az(flag_az), .flag_an(flag_an), .flag_ac(flag_ac), .flag_av(flag_av));

// File: verification/compute_unit_tb.sv
// compute unit testbench with reference model, directed tests, compare tasks and timeout
`timescale 1ns/1ps
`include "dsp_defs.svh"

module compute_unit_tb;

	localparam int          W    = `DSP_DATA_WIDTH;
	localparam logic [31:0] SEED = 32'hd25c7ab5;

	// cycles per test as loads plus ops plus one drain edge per program
	localparam int TEST_CYCLES = 4   // reset
		+ 9                          // reset state
		+ 4 * (2 + 7) + 6            // logical
		+ 8 * (2 + 5) + 8 + 1        // add, subtract, sticky clear
		+ 4 + 7                      // carry chain
		+ 6 * (2 + 8)                // min, max, negate, pass, abs
		+ 2 * (16 + 9)               // compares
		+ 2 + 6 + 2;                 // bypass
	localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

	// ********************
	// opcodes as {sat, log, hc, sc}
	// ********************

	localparam logic [6:0] OP_AND  = 7'b0_1_00_000;
	localparam logic [6:0] OP_OR   = 7'b0_1_00_001;
	localparam logic [6:0] OP_XOR  = 7'b0_1_00_010;
	localparam logic [6:0] OP_RAND = 7'b0_1_10_000; // reduce-AND
	localparam logic [6:0] OP_ROR  = 7'b0_1_10_001; // reduce-OR
	localparam logic [6:0] OP_NOT  = 7'b0_1_11_000;
	localparam logic [6:0] OP_ADD  = 7'b0_0_00_000;
	localparam logic [6:0] OP_SUB  = 7'b0_0_00_001;
	localparam logic [6:0] OP_ADC  = 7'b0_0_00_010;
	localparam logic [6:0] OP_SBB  = 7'b0_0_00_011;
	localparam logic [6:0] OP_CMP  = 7'b0_0_00_101;
	localparam logic [6:0] OP_MIN  = 7'b0_0_01_001;
	localparam logic [6:0] OP_MAX  = 7'b0_0_01_011;
	localparam logic [6:0] OP_PASS = 7'b0_0_10_000;
	localparam logic [6:0] OP_NEG  = 7'b0_0_10_001;
	localparam logic [6:0] OP_ABS  = 7'b0_0_11_000;
	localparam logic [6:0] SAT     = 7'b1_0_00_000; // or'd into an arithmetic op

	logic                       clk, reset, instr_valid, load_en, sticky_clear;
	dsp_pkg::instr_t            instr;
	dsp_pkg::reg_idx_t          load_addr;
	dsp_pkg::data_t             load_data, result;
	logic                       result_valid, flag_az, flag_an, flag_ac, flag_av, sticky_ov;
	logic [`DSP_CACC_DEPTH-1:0] cacc;

	// reference state
	dsp_pkg::data_t             model_regs [`DSP_REG_COUNT];
	logic                       model_ac, model_sticky;
	logic [`DSP_CACC_DEPTH-1:0] model_cacc;
	dsp_pkg::instr_t            prog [$]; // next program to issue
	int                         errors, tests, failed_tests, test_start;
	int                         assertion_fails; // bound failures already counted
	int unsigned                cycles, seed_state;

	compute_unit dut0 (.clk, .reset, .instr_valid, .instr, .load_en, .load_addr, .load_data,
		.sticky_clear, .result, .result_valid, .flag_az, .flag_an, .flag_ac, .flag_av,
		.sticky_ov, .cacc);

	always #2 clk = ~clk; // 4 ns period

	// ********************
	// reference model
	// ********************

	function automatic void predict(input dsp_pkg::instr_t op, input dsp_pkg::data_t x, y,
		input logic ci, output dsp_pkg::data_t r, output logic ac, av, cmp);
		dsp_pkg::data_t a, b;
		logic           cin;
		logic [W:0]     s;
		r   = '0;
		ac  = 1'b0;
		av  = 1'b0;
		cmp = 1'b0;
		a   = x;
		b   = '0;
		cin = 1'b0;
		if (op.log)
		begin
			case (op.hc)
				2'b00:
				begin
					case (op.sc[1:0])
						2'b00:   r = x & y;
						2'b01:   r = x | y;
						2'b10:   r = x ^ y;
						default: r = '0;
					endcase
				end
				2'b10:   r = {{(W-1){1'b0}}, (op.sc[0] ? |x : &x)};
				2'b11:   r = ~x;
				default: r = '0;
			endcase
		end
		else if (op.hc == 2'b00 && op.sc == 3'b101)
		begin
			cmp = 1'b1; // ffff less, 0000 equal, 0001 greater
			if ($signed(x) < $signed(y))
				r = '1;
			else if (x == y)
				r = '0;
			else
				r = dsp_pkg::data_t'(1);
		end
		else if (op.hc == 2'b01)
		begin
			if (op.sc[1])
				r = ($signed(x) > $signed(y)) ? x : y; // max
			else
				r = ($signed(x) < $signed(y)) ? x : y; // min
		end
		else
		begin
			case (op.hc)
				2'b00:
				begin
					b   = op.sc[0] ? ~y : y;           // x - y is x + ~y + 1
					cin = op.sc[1] ? ci : op.sc[0];   // borrow form is x + ~y + ci
				end
				2'b10:
				begin
					a   = op.sc[0] ? '0 : x; // negate as 0 - x
					b   = op.sc[0] ? ~x : '0;
					cin = op.sc[0];
				end
				default:
				begin
					a   = x[W-1] ? '0 : x; // abs negates only negative x
					b   = x[W-1] ? ~x : '0;
					cin = x[W-1];
				end
			endcase
			s  = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin};
			r  = s[W-1:0];
			ac = s[W];
			av = (a[W-1] == b[W-1]) && (s[W-1] != a[W-1]);
			if (op.sat && av)
				r = a[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
		end
	endfunction

	function automatic dsp_pkg::data_t random_word();
		return dsp_pkg::data_t'($urandom());
	endfunction

	// ********************
	// compare tasks
	// ********************

	task automatic check_data(input string name, input dsp_pkg::data_t got, exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_cacc(input logic [`DSP_CACC_DEPTH-1:0] got, exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED cacc got %h expected %h at %0t", got, exp, $time);
			errors++;
		end
	endtask

	// ********************
	// drivers
	// ********************

	task automatic tick();
		@(posedge clk);
		#1; // drive point
	endtask

	task automatic load_reg(input dsp_pkg::reg_idx_t idx, input dsp_pkg::data_t val);
		load_en   = 1'b1;
		load_addr = idx;
		load_data = val;
		tick();
		load_en         = 1'b0;
		model_regs[idx] = val;
	endtask

	task automatic add_op(input logic [6:0] code, input dsp_pkg::reg_idx_t rn, rx, ry);
		prog.push_back({code, rn, rx, ry});
	endtask

	// issues the program back-to-back, result checked in the execute cycle,
	// flags one edge later
	task automatic run_prog();
		dsp_pkg::data_t             exp_r [$];
		logic [4:0]                 exp_f [$]; // az an ac av sticky
		logic [`DSP_CACC_DEPTH-1:0] exp_c [$];
		dsp_pkg::data_t             r;
		logic                       ac, av, cmp;
		int                         n;
		n = prog.size();
		for (int k = 0; k <= n + 1; k++)
		begin
			if (k >= 1 && k <= n)
			begin
				check_bit("result_valid", result_valid, 1'b1);
				check_data("result", result, exp_r[k-1]);
			end
			if (k >= 2)
			begin
				check_bit("flag_az", flag_az, exp_f[k-2][4]);
				check_bit("flag_an", flag_an, exp_f[k-2][3]);
				check_bit("flag_ac", flag_ac, exp_f[k-2][2]);
				check_bit("flag_av", flag_av, exp_f[k-2][1]);
				check_bit("sticky_ov", sticky_ov, exp_f[k-2][0]);
				check_cacc(cacc, exp_c[k-2]);
			end
			if (k < n)
			begin
				predict(prog[k], model_regs[prog[k].rx], model_regs[prog[k].ry], model_ac,
					r, ac, av, cmp);
				model_regs[prog[k].rn] = r; // later reads see it, as the bypass does
				model_ac               = ac;
				model_sticky           = model_sticky | av;
				if (cmp)
					model_cacc = {model_cacc[`DSP_CACC_DEPTH-2:0], r[W-1]};
				exp_r.push_back(r);
				exp_f.push_back({(r == '0), r[W-1], ac, av, model_sticky});
				exp_c.push_back(model_cacc);
				instr       = prog[k];
				instr_valid = 1'b1;
			end
			else
				instr_valid = 1'b0;
			if (k <= n)
				tick();
		end
		check_bit("result_valid", result_valid, 1'b0);
		prog.delete();
	endtask

	task automatic end_test(input string name);
		errors          += dut0.u_checks.fail_count - assertion_fails; // bound checks
		assertion_fails  = dut0.u_checks.fail_count;
		tests++;
		if (errors == test_start)
			$display("test %s ok", name);
		else
		begin
			failed_tests++;
			$display("test %s: %0d check(s) wrong", name, errors - test_start);
		end
	endtask

	// ********************
	// tests
	// ********************

	task automatic test_reset_state();
		test_start = errors;
		for (int i = 0; i < 8; i++)
			add_op(OP_OR, dsp_pkg::reg_idx_t'(2*i), dsp_pkg::reg_idx_t'(2*i),
				dsp_pkg::reg_idx_t'(2*i+1)); // every register pair reads zero
		run_prog();
		end_test("reset state");
	endtask

	task automatic test_logic();
		test_start = errors;
		for (int i = 0; i < 4; i++)
		begin
			load_reg(4'd1, random_word());
			load_reg(4'd2, random_word());
			add_op(OP_AND, 4'd3, 4'd1, 4'd2);
			add_op(OP_OR, 4'd4, 4'd1, 4'd2);
			add_op(OP_XOR, 4'd5, 4'd1, 4'd2);
			add_op(OP_NOT, 4'd6, 4'd1, 4'd2);
			add_op(OP_ROR, 4'd7, 4'd1, 4'd2);
			add_op(OP_RAND, 4'd8, 4'd2, 4'd1);
			run_prog();
		end
		load_reg(4'd9, 16'hffff);
		load_reg(4'd10, 16'h0000);
		add_op(OP_RAND, 4'd11, 4'd9, 4'd9);  // all ones gives 1
		add_op(OP_ROR, 4'd12, 4'd10, 4'd10); // zero, AZ set
		add_op(OP_AND, 4'd13, 4'd9, 4'd10);
		run_prog();
		end_test("logical ops");
	endtask

	task automatic test_add_sub();
		test_start = errors;
		for (int i = 0; i < 8; i++)
		begin
			load_reg(4'd1, random_word());
			load_reg(4'd2, random_word());
			add_op(OP_ADD, 4'd3, 4'd1, 4'd2);
			add_op(OP_SUB, 4'd4, 4'd1, 4'd2);
			add_op(OP_ADD | SAT, 4'd5, 4'd1, 4'd2);
			add_op(OP_SUB | SAT, 4'd6, 4'd1, 4'd2);
			run_prog();
		end
		// overflow both ways
		load_reg(4'd1, 16'h7000);
		load_reg(4'd2, 16'h7000);
		load_reg(4'd3, 16'h8000);
		load_reg(4'd4, 16'h0001);
		add_op(OP_ADD | SAT, 4'd5, 4'd1, 4'd2); // clamps to 7fff
		add_op(OP_SUB | SAT, 4'd6, 4'd3, 4'd4); // clamps to 8000
		add_op(OP_ADD, 4'd7, 4'd1, 4'd2);       // wraps
		run_prog();
		check_bit("sticky_ov", sticky_ov, 1'b1);
		sticky_clear = 1'b1;
		tick();
		sticky_clear = 1'b0;
		model_sticky = 1'b0;
		check_bit("sticky_ov", sticky_ov, 1'b0);
		end_test("add and subtract");
	endtask

	task automatic test_carry();
		test_start = errors;
		load_reg(4'd1, 16'hffff);
		load_reg(4'd2, 16'h0001);
		load_reg(4'd3, 16'h1234);
		load_reg(4'd4, 16'h0010);
		add_op(OP_ADD, 4'd5, 4'd3, 4'd4);  // no carry out
		add_op(OP_ADC, 4'd6, 4'd1, 4'd2);  // ci 0, carries
		add_op(OP_ADD, 4'd7, 4'd1, 4'd2);  // carries
		add_op(OP_ADC, 4'd8, 4'd3, 4'd4);  // ci 1
		add_op(OP_SBB, 4'd9, 4'd3, 4'd4);  // ci 0, one extra borrowed
		add_op(OP_SBB, 4'd10, 4'd3, 4'd4); // ci 1
		run_prog();
		end_test("carry chain");
	endtask

	task automatic test_signed();
		dsp_pkg::data_t vals [12] = '{16'h8000, 16'h0005, 16'h7fff, 16'h8000, 16'h0005,
			16'hfffb, 16'hfffb, 16'h0000, 16'h0000, 16'h8000, 16'h0000, 16'h0000};
		test_start = errors;
		for (int i = 0; i < 6; i++)
		begin
			load_reg(4'd1, (i == 5) ? random_word() : vals[2*i]);
			load_reg(4'd2, (i == 5) ? random_word() : vals[2*i+1]);
			add_op(OP_MIN, 4'd3, 4'd1, 4'd2);
			add_op(OP_MAX, 4'd4, 4'd1, 4'd2);
			add_op(OP_NEG, 4'd5, 4'd1, 4'd2);
			add_op(OP_PASS, 4'd6, 4'd1, 4'd2);
			add_op(OP_ABS, 4'd7, 4'd1, 4'd2);
			add_op(OP_NEG, 4'd8, 4'd2, 4'd1);
			add_op(OP_ABS, 4'd9, 4'd2, 4'd1);
			run_prog();
		end
		end_test("signed ops");
	endtask

	task automatic test_compare();
		dsp_pkg::data_t pairs [16] = '{16'h0001, 16'h0002, 16'h0002, 16'h0002, 16'h0005,
			16'hfffd, 16'hfffd, 16'h0005, 16'h8000, 16'h7fff, 16'h7fff, 16'h8000,
			16'h0000, 16'h0000, 16'hffff, 16'h0000};
		test_start = errors;
		// first batch known orderings, second random and shifts the first out
		for (int b = 0; b < 2; b++)
		begin
			for (int i = 0; i < 16; i++)
				load_reg(dsp_pkg::reg_idx_t'(i), (b == 0) ? pairs[i] : random_word());
			for (int i = 0; i < 8; i++)
				add_op(OP_CMP, dsp_pkg::reg_idx_t'(2*i), dsp_pkg::reg_idx_t'(2*i),
					dsp_pkg::reg_idx_t'(2*i+1));
			run_prog();
		end
		end_test("compare");
	endtask

	task automatic test_bypass();
		test_start = errors;
		load_reg(4'd1, random_word());
		load_reg(4'd2, random_word());
		add_op(OP_ADD, 4'd3, 4'd1, 4'd2);
		add_op(OP_SUB, 4'd4, 4'd3, 4'd1);  // r3 still in flight
		add_op(OP_XOR, 4'd3, 4'd4, 4'd3);  // r4 bypassed, r3 from the file
		add_op(OP_ADD, 4'd5, 4'd3, 4'd3);
		add_op(OP_PASS, 4'd6, 4'd5, 4'd5);
		run_prog();
		add_op(OP_PASS, 4'd7, 4'd3, 4'd3); // written value, no bypass
		run_prog();
		end_test("bypass");
	endtask

	// ********************
	// run control
	// ********************

	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, run still going after %0d cycles", cycles);
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		seed_state      = $urandom(SEED);
		clk             = 1'b0;
		reset           = 1'b0;
		instr_valid     = 1'b0;
		instr           = '0;
		load_en         = 1'b0;
		load_addr       = '0;
		load_data       = '0;
		sticky_clear    = 1'b0;
		errors          = 0;
		tests           = 0;
		failed_tests    = 0;
		test_start      = 0;
		assertion_fails = 0;
		model_ac        = 1'b0;
		model_sticky    = 1'b0;
		model_cacc      = '0;
		for (int i = 0; i < `DSP_REG_COUNT; i++)
			model_regs[i] = '0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b1;
		test_reset_state();
		test_logic();
		test_add_sub();
		test_carry();
		test_signed();
		test_compare();
		test_bypass();
		$display("tests %0d, tests failed %0d, checks failed %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
